// File: logic/spr_map_pkg.sv
package spr_map_pkg;

	// Group number sits in address bits 15:11
	localparam int GRP_W = 5;
	localparam int IDX_W = 11;

	localparam logic [GRP_W-1:0] GRP_SYS = 5'd0;
	localparam logic [GRP_W-1:0] GRP_PIC = 5'd9;
	localparam logic [GRP_W-1:0] GRP_TT  = 5'd10;

	// System group
	localparam logic [IDX_W-1:0] SPR_VR   = 11'd0;
	localparam logic [IDX_W-1:0] SPR_SR   = 11'd17;
	localparam logic [IDX_W-1:0] SPR_EPCR = 11'd32;
	localparam logic [IDX_W-1:0] SPR_EEAR = 11'd48;
	localparam logic [IDX_W-1:0] SPR_ESR  = 11'd64;

	// PIC group
	localparam logic [IDX_W-1:0] SPR_PICMR = 11'd0;
	localparam logic [IDX_W-1:0] SPR_PICSR = 11'd2;

	// Tick-timer group
	localparam logic [IDX_W-1:0] SPR_TTMR = 11'd0;
	localparam logic [IDX_W-1:0] SPR_TTCR = 11'd1;

	// Version 0x12, revision 1
	localparam logic [31:0] VR_VALUE = 32'h1200_0001;

	// Write strobe, register index and data shared by all groups
	typedef struct packed {
		logic             we;
		logic [IDX_W-1:0] index;
		logic [31:0]      wdata;
	} spr_bus_t;

	// One bit per SPR group
	typedef logic [31:0] spr_cs_t;

endpackage

// File: logic/cpu_state_pkg.sv
package cpu_state_pkg;

	// Supervision register bits, high to low
	typedef struct packed {
		logic FO;
		logic EPH;
		logic DSX;
		logic OVE;
		logic OV;
		logic CY;
		logic F;
		logic CE;
		logic LEE;
		logic IME;
		logic DME;
		logic ICE;
		logic DCE;
		logic IEE;
		logic TEE;
		logic SM;
	} sr_fields_t;

	typedef union packed {
		sr_fields_t  fld; // Named bits for updates
		logic [15:0] raw; // Whole word for mtspr and ESR
	} sr_word_u;

	localparam logic [15:0] SR_RESET = 16'h8001; // FO and SM set

	typedef enum logic [1:0] {
		NONE  = 2'd0,
		MTSPR = 2'd1,
		MFSPR = 2'd2
	} spr_op_e;

	typedef struct packed {
		logic        valid;
		spr_op_e     op;
		logic [31:0] addr;
		logic [31:0] data;
	} spr_req_t;

	typedef struct packed {
		logic        valid;
		logic        from_dbg;
		logic [31:0] data;
	} spr_rsp_t;

	// ALU flag and carry forwarding
	typedef struct packed {
		logic flag_we;
		logic flag;
		logic cy_we;
		logic cy;
	} alu_upd_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] epc;
		logic [31:0] eear;
	} except_t;

endpackage

// File: logic/spr_access.sv
`timescale 1ns/1ps

module spr_access (
	input  logic                    clk,
	input  logic                    rst,
	input  cpu_state_pkg::spr_req_t cpu_req_i,
	input  cpu_state_pkg::spr_req_t dbg_req_i,
	input  logic [31:0]             sys_rdata_i,
	input  logic [31:0]             pic_rdata_i,
	input  logic [31:0]             tt_rdata_i,
	output spr_map_pkg::spr_bus_t   bus_o,
	output spr_map_pkg::spr_cs_t    cs_o,
	output cpu_state_pkg::spr_rsp_t rsp_o
);

	cpu_state_pkg::spr_req_t req;
	logic [spr_map_pkg::GRP_W-1:0] grp;
	logic                          wr_req;
	logic                          rd_req;
	logic [31:0]                   rdata;
	logic                          rsp_valid_q;
	logic                          rsp_dbg_q;
	logic [31:0]                   rsp_data_q;

	// Debug unit wins, a colliding CPU request is dropped
	assign req = dbg_req_i.valid ? dbg_req_i : cpu_req_i;

	assign grp    = req.addr[15:11];
	assign wr_req = req.valid && (req.op == cpu_state_pkg::MTSPR);
	assign rd_req = req.valid && (req.op == cpu_state_pkg::MFSPR);

	assign bus_o.we    = wr_req;
	assign bus_o.index = req.addr[spr_map_pkg::IDX_W-1:0];
	assign bus_o.wdata = req.data;

	// One-hot group select, only while a request is live
	always_comb begin
		cs_o = '0;
		if (wr_req || rd_req)
			cs_o[grp] = 1'b1;
	end

	always_comb begin
		case (grp)
			spr_map_pkg::GRP_SYS: rdata = sys_rdata_i;
			spr_map_pkg::GRP_PIC: rdata = pic_rdata_i;
			spr_map_pkg::GRP_TT:  rdata = tt_rdata_i;
			default:              rdata = '0; // MMU, cache, MAC, PM, DU
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rsp_valid_q <= 1'b0;
			rsp_dbg_q   <= 1'b0;
		end else begin
			rsp_valid_q <= rd_req;
			rsp_dbg_q   <= dbg_req_i.valid; // Tag the source of the read
		end
	end

	always_ff @(posedge clk) begin
		if (rd_req)
			rsp_data_q <= rdata;
	end

	assign rsp_o.valid    = rsp_valid_q;
	assign rsp_o.from_dbg = rsp_dbg_q;
	assign rsp_o.data     = rsp_data_q;

	// At most one group is ever addressed
	a_cs_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(cs_o));

	// A response only appears one cycle after a read request
	a_rsp_after_read: assert property (@(posedge clk) disable iff (rst)
		rsp_o.valid |-> $past(rd_req));

endmodule

// File: logic/sys_sprs.sv
`timescale 1ns/1ps

module sys_sprs (
	input  logic                      clk,
	input  logic                      rst,
	input  spr_map_pkg::spr_bus_t     bus_i,
	input  logic                      sel_i,
	input  cpu_state_pkg::alu_upd_t   alu_i,
	input  cpu_state_pkg::except_t    except_i,
	input  logic                      rfe_i,
	output logic [31:0]               rdata_o,
	output cpu_state_pkg::sr_fields_t sr_o
);

	cpu_state_pkg::sr_word_u sr_q;
	cpu_state_pkg::sr_word_u sr_d;
	logic [15:0]             esr_q;
	logic [31:0]             epcr_q;
	logic [31:0]             eear_q;
	logic                    wr;
	logic                    sr_wr;
	logic                    epcr_wr;
	logic                    eear_wr;
	logic                    esr_wr;

	assign wr      = sel_i && bus_i.we;
	assign sr_wr   = wr && (bus_i.index == spr_map_pkg::SPR_SR);
	assign epcr_wr = wr && (bus_i.index == spr_map_pkg::SPR_EPCR);
	assign eear_wr = wr && (bus_i.index == spr_map_pkg::SPR_EEAR);
	assign esr_wr  = wr && (bus_i.index == spr_map_pkg::SPR_ESR);

	// Next SR: exception entry, then rfe, then ALU over software write
	always_comb begin
		sr_d = sr_q;
		if (except_i.valid) begin
			sr_d.fld.SM  = 1'b1; // Enter supervisor mode
			sr_d.fld.IEE = 1'b0;
			sr_d.fld.TEE = 1'b0;
			sr_d.fld.IME = 1'b0;
			sr_d.fld.DME = 1'b0;
		end else if (rfe_i) begin
			sr_d.raw = esr_q;
		end else begin
			if (sr_wr)
				sr_d.raw = bus_i.wdata[15:0];
			if (alu_i.flag_we)
				sr_d.fld.F = alu_i.flag;
			if (alu_i.cy_we)
				sr_d.fld.CY = alu_i.cy;
		end
		sr_d.fld.FO = 1'b1; // Hardwired one
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sr_q.raw <= cpu_state_pkg::SR_RESET;
			esr_q    <= cpu_state_pkg::SR_RESET;
		end else begin
			sr_q <= sr_d;
			if (except_i.valid)
				esr_q <= sr_q.raw; // Save SR as it was before entry
			else if (esr_wr)
				esr_q <= bus_i.wdata[15:0];
		end
	end

	always_ff @(posedge clk) begin
		if (except_i.valid) begin
			epcr_q <= except_i.epc;
			eear_q <= except_i.eear;
		end else begin
			if (epcr_wr)
				epcr_q <= bus_i.wdata;
			if (eear_wr)
				eear_q <= bus_i.wdata;
		end
	end

	always_comb begin
		rdata_o = '0;
		if (sel_i) begin
			case (bus_i.index)
				spr_map_pkg::SPR_VR:   rdata_o = spr_map_pkg::VR_VALUE;
				spr_map_pkg::SPR_SR:   rdata_o = {16'h0000, sr_q.raw};
				spr_map_pkg::SPR_EPCR: rdata_o = epcr_q;
				spr_map_pkg::SPR_EEAR: rdata_o = eear_q;
				spr_map_pkg::SPR_ESR:  rdata_o = {16'h0000, esr_q};
				default:               rdata_o = '0;
			endcase
		end
	end

	assign sr_o = sr_q.fld;

	// FO survives every update path, including rfe from a written ESR
	a_fo_set: assert property (@(posedge clk) disable iff (rst)
		sr_q.fld.FO);

endmodule

// File: logic/pic_sprs.sv
`timescale 1ns/1ps

module pic_sprs (
	input  logic                  clk,
	input  logic                  rst,
	input  spr_map_pkg::spr_bus_t bus_i,
	input  logic                  sel_i,
	input  logic [31:0]           irq_i,
	input  logic                  iee_i,
	output logic [31:0]           rdata_o,
	output logic                  pic_int_o
);

	logic [31:0] picmr_q;
	logic [31:0] picsr_q;
	logic        picmr_wr;
	logic        picsr_wr;

	assign picmr_wr = sel_i && bus_i.we && (bus_i.index == spr_map_pkg::SPR_PICMR);
	assign picsr_wr = sel_i && bus_i.we && (bus_i.index == spr_map_pkg::SPR_PICSR);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			picmr_q   <= '0;
			picsr_q   <= '0;
			pic_int_o <= 1'b0;
		end else begin
			if (picmr_wr)
				picmr_q <= bus_i.wdata;
			picsr_q   <= (picsr_wr ? bus_i.wdata : picsr_q) | irq_i; // Sticky until cleared
			pic_int_o <= iee_i && |(picsr_q & picmr_q);
		end
	end

	always_comb begin
		rdata_o = '0;
		if (sel_i) begin
			case (bus_i.index)
				spr_map_pkg::SPR_PICMR: rdata_o = picmr_q;
				spr_map_pkg::SPR_PICSR: rdata_o = picsr_q;
				default:                rdata_o = '0;
			endcase
		end
	end

endmodule

// File: logic/tick_timer.sv
`timescale 1ns/1ps

module tick_timer (
	input  logic                  clk,
	input  logic                  rst,
	input  spr_map_pkg::spr_bus_t bus_i,
	input  logic                  sel_i,
	input  logic                  tee_i,
	output logic [31:0]           rdata_o,
	output logic                  tick_int_o
);

	logic [31:0] ttmr_q;
	logic [31:0] ttcr_q;
	logic [1:0]  mode;
	logic [31:0] period;
	logic        match;
	logic        ttmr_wr;
	logic        ttcr_wr;

	assign mode    = ttmr_q[31:30];
	assign period  = {4'h0, ttmr_q[27:0]};
	assign match   = (ttcr_q == period);
	assign ttmr_wr = sel_i && bus_i.we && (bus_i.index == spr_map_pkg::SPR_TTMR);
	assign ttcr_wr = sel_i && bus_i.we && (bus_i.index == spr_map_pkg::SPR_TTCR);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ttmr_q     <= '0;
			ttcr_q     <= '0;
			tick_int_o <= 1'b0;
		end else begin
			if (ttmr_wr)
				ttmr_q <= bus_i.wdata; // Software write also clears IP
			else if (match && (mode != 2'd0))
				ttmr_q[28] <= 1'b1;
			if (ttcr_wr)
				ttcr_q <= bus_i.wdata;
			else if (mode == 2'd1)
				ttcr_q <= match ? 32'd0 : ttcr_q + 32'd1; // Restart
			else if ((mode == 2'd2 && !match) || mode == 2'd3)
				ttcr_q <= ttcr_q + 32'd1; // One-shot stops on match
			tick_int_o <= ttmr_q[29] && ttmr_q[28] && tee_i;
		end
	end

	assign rdata_o = !sel_i ? 32'd0 :
		(bus_i.index == spr_map_pkg::SPR_TTMR) ? ttmr_q :
		(bus_i.index == spr_map_pkg::SPR_TTCR) ? ttcr_q : 32'd0;

	// Restart mode keeps the count inside the period once it is there
	a_restart_bound: assert property (@(posedge clk) disable iff (rst)
		(mode == 2'd1 && ttcr_q <= period && !ttmr_wr && !ttcr_wr) |=> ttcr_q <= period);

endmodule

// File: logic/spr_subsys.sv
`timescale 1ns/1ps

module spr_subsys (
	input  logic                      clk,
	input  logic                      rst,
	input  cpu_state_pkg::spr_req_t   cpu_req_i,
	input  cpu_state_pkg::spr_req_t   dbg_req_i,
	input  cpu_state_pkg::alu_upd_t   alu_i,
	input  cpu_state_pkg::except_t    except_i,
	input  logic                      rfe_i,
	input  logic [31:0]               irq_i,
	output cpu_state_pkg::spr_rsp_t   rsp_o,
	output cpu_state_pkg::sr_fields_t sr_o,
	output logic                      pic_int_o,
	output logic                      tick_int_o
);

	spr_map_pkg::spr_bus_t spr_bus;
	spr_map_pkg::spr_cs_t  spr_cs;
	logic [31:0]           sys_rdata;
	logic [31:0]           pic_rdata;
	logic [31:0]           tt_rdata;

	spr_access u_access (
		.clk         (clk),
		.rst         (rst),
		.cpu_req_i   (cpu_req_i),
		.dbg_req_i   (dbg_req_i),
		.sys_rdata_i (sys_rdata),
		.pic_rdata_i (pic_rdata),
		.tt_rdata_i  (tt_rdata),
		.bus_o       (spr_bus),
		.cs_o        (spr_cs),
		.rsp_o       (rsp_o)
	);

	sys_sprs u_sys (
		.clk      (clk),
		.rst      (rst),
		.bus_i    (spr_bus),
		.sel_i    (spr_cs[spr_map_pkg::GRP_SYS]),
		.alu_i    (alu_i),
		.except_i (except_i),
		.rfe_i    (rfe_i),
		.rdata_o  (sys_rdata),
		.sr_o     (sr_o)
	);

	pic_sprs u_pic (
		.clk       (clk),
		.rst       (rst),
		.bus_i     (spr_bus),
		.sel_i     (spr_cs[spr_map_pkg::GRP_PIC]),
		.irq_i     (irq_i),
		.iee_i     (sr_o.IEE), // Global interrupt enable
		.rdata_o   (pic_rdata),
		.pic_int_o (pic_int_o)
	);

	tick_timer u_tt (
		.clk        (clk),
		.rst        (rst),
		.bus_i      (spr_bus),
		.sel_i      (spr_cs[spr_map_pkg::GRP_TT]),
		.tee_i      (sr_o.TEE), // Tick exception enable
		.rdata_o    (tt_rdata),
		.tick_int_o (tick_int_o)
	);

endmodule

// File: dv/spr_subsys_tb.sv
`timescale 1ns/1ps

module spr_subsys_tb;

	localparam int          WAIT_LIMIT = 200;
	localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

	logic                      clk;
	logic                      rst;
	cpu_state_pkg::spr_req_t   cpu_req;
	cpu_state_pkg::spr_req_t   dbg_req;
	cpu_state_pkg::alu_upd_t   alu;
	cpu_state_pkg::except_t    exc;
	logic                      rfe;
	logic [31:0]               irq;
	cpu_state_pkg::spr_rsp_t   rsp;
	cpu_state_pkg::sr_fields_t sr;
	logic                      pic_int;
	logic                      tick_int;
	logic [31:0]               lfsr_state;
	int                        mismatches;
	int                        timeouts;

	spr_subsys UUT (
		.clk        (clk),
		.rst        (rst),
		.cpu_req_i  (cpu_req),
		.dbg_req_i  (dbg_req),
		.alu_i      (alu),
		.except_i   (exc),
		.rfe_i      (rfe),
		.irq_i      (irq),
		.rsp_o      (rsp),
		.sr_o       (sr),
		.pic_int_o  (pic_int),
		.tick_int_o (tick_int)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// One LFSR step per bit handed out
	function automatic logic [31:0] take_bits(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic logic [31:0] make_addr(input logic [4:0] grp, input logic [10:0] idx);
		return {16'h0000, grp, idx}; // Group in bits 15:11
	endfunction

	function automatic cpu_state_pkg::spr_req_t make_req(input cpu_state_pkg::spr_op_e op,
		input logic [31:0] addr, input logic [31:0] data);
		cpu_state_pkg::spr_req_t req;
		req.valid = 1'b1;
		req.op    = op;
		req.addr  = addr;
		req.data  = data;
		return req;
	endfunction

	task automatic note_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic write_spr(input logic dbg, input logic [31:0] addr, input logic [31:0] data);
		if (dbg)
			dbg_req = make_req(cpu_state_pkg::MTSPR, addr, data);
		else
			cpu_req = make_req(cpu_state_pkg::MTSPR, addr, data);
		@(negedge clk);
		cpu_req = '0;
		dbg_req = '0;
	endtask

	task automatic read_spr(input logic dbg, input logic [31:0] addr,
		output logic [31:0] data, output logic tag, output int lat);
		if (dbg)
			dbg_req = make_req(cpu_state_pkg::MFSPR, addr, 32'h0);
		else
			cpu_req = make_req(cpu_state_pkg::MFSPR, addr, 32'h0);
		@(negedge clk);
		cpu_req = '0;
		dbg_req = '0;
		lat = 1;
		while (!rsp.valid && lat < WAIT_LIMIT) begin
			@(negedge clk);
			lat++;
		end
		if (!rsp.valid) begin
			$display("timeout waiting for the read response of address %h", addr);
			timeouts++;
		end
		data = rsp.data;
		tag  = rsp.from_dbg;
	endtask

	task automatic expect_read(input logic dbg, input logic [31:0] addr,
		input logic [31:0] exp, input string name);
		logic [31:0] data;
		logic        tag;
		int          lat;
		read_spr(dbg, addr, data, tag, lat);
		if (data !== exp)
			note_mismatch({"rsp_o.data for ", name}, data, exp);
		if (tag !== dbg)
			note_mismatch({"rsp_o.from_dbg for ", name}, {31'h0, tag}, {31'h0, dbg});
		if (lat != 1)
			note_mismatch({"response latency for ", name}, lat, 32'd1);
	endtask

	task automatic wait_int(input logic tick, input logic level);
		int    n;
		string name;
		n = 0;
		if (tick)
			name = "tick_int_o";
		else
			name = "pic_int_o";
		while ((tick ? tick_int : pic_int) !== level && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if ((tick ? tick_int : pic_int) !== level) begin
			$display("timeout waiting for %s to become %b", name, level);
			timeouts++;
		end
	endtask

	task automatic check_reset_state();
		if (pic_int !== 1'b0)
			note_mismatch("pic_int_o", {31'h0, pic_int}, 32'h0);
		if (tick_int !== 1'b0)
			note_mismatch("tick_int_o", {31'h0, tick_int}, 32'h0);
		if (rsp.valid !== 1'b0)
			note_mismatch("rsp_o.valid", {31'h0, rsp.valid}, 32'h0);
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR), 32'h8001, "SR");
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_VR),
			spr_map_pkg::VR_VALUE, "VR");
	endtask

	task automatic round_trip();
		logic [31:0] d;
		logic [31:0] epcr_val;
		logic [31:0] picmr_val;
		epcr_val = take_bits(32);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EPCR), epcr_val);
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EPCR), epcr_val, "EPCR");
		picmr_val = take_bits(32);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_PIC, spr_map_pkg::SPR_PICMR), picmr_val);
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_PIC, spr_map_pkg::SPR_PICMR), picmr_val,
			"PICMR");
		d = take_bits(32) & 32'h1fff_ffff; // Mode 0 and IE clear keep the timer quiet
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_TT, spr_map_pkg::SPR_TTMR), d);
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_TT, spr_map_pkg::SPR_TTMR), d, "TTMR");
		d = take_bits(32);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR), d);
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR),
			{16'h0000, d[15:0] | 16'h8000}, "SR");
		expect_read(1'b0, make_addr(5'd5, 11'd0), 32'h0, "group 5");
		// Two reads on consecutive cycles
		cpu_req = make_req(cpu_state_pkg::MFSPR,
			make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EPCR), 32'h0);
		@(negedge clk);
		cpu_req = make_req(cpu_state_pkg::MFSPR,
			make_addr(spr_map_pkg::GRP_PIC, spr_map_pkg::SPR_PICMR), 32'h0);
		if (rsp.valid !== 1'b1)
			note_mismatch("rsp_o.valid first", {31'h0, rsp.valid}, 32'h1);
		if (rsp.data !== epcr_val)
			note_mismatch("rsp_o.data first", rsp.data, epcr_val);
		@(negedge clk);
		cpu_req = '0;
		if (rsp.valid !== 1'b1)
			note_mismatch("rsp_o.valid second", {31'h0, rsp.valid}, 32'h1);
		if (rsp.data !== picmr_val)
			note_mismatch("rsp_o.data second", rsp.data, picmr_val);
		@(negedge clk);
		if (rsp.valid !== 1'b0)
			note_mismatch("rsp_o.valid after burst", {31'h0, rsp.valid}, 32'h0);
	endtask

	task automatic debug_priority();
		logic [31:0] cpu_val;
		logic [31:0] dbg_val;
		cpu_val = take_bits(32);
		dbg_val = ~cpu_val;
		cpu_req = make_req(cpu_state_pkg::MTSPR,
			make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EEAR), cpu_val);
		dbg_req = make_req(cpu_state_pkg::MTSPR,
			make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EEAR), dbg_val);
		@(negedge clk);
		cpu_req = '0;
		dbg_req = '0;
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EEAR), dbg_val, "EEAR");
		expect_read(1'b1, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EEAR), dbg_val,
			"EEAR by debug");
	endtask

	task automatic exception_entry_return();
		cpu_state_pkg::sr_fields_t old_sr;
		cpu_state_pkg::sr_fields_t expect_sr;
		logic [31:0]               d;
		logic [31:0]               epc;
		logic [31:0]               eear;
		d = take_bits(16) | 32'h0066; // IME, DME, IEE and TEE set
		old_sr = d[15:0] | 16'h8000;
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR), d);
		if (sr !== old_sr)
			note_mismatch("sr_o before entry", {16'h0, sr}, {16'h0, old_sr});
		epc  = take_bits(32);
		eear = take_bits(32);
		exc.valid = 1'b1;
		exc.epc   = epc;
		exc.eear  = eear;
		@(negedge clk);
		exc = '0;
		expect_sr     = old_sr;
		expect_sr.SM  = 1'b1;
		expect_sr.IEE = 1'b0;
		expect_sr.TEE = 1'b0;
		expect_sr.IME = 1'b0;
		expect_sr.DME = 1'b0;
		if (sr !== expect_sr)
			note_mismatch("sr_o after entry", {16'h0, sr}, {16'h0, expect_sr});
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EPCR), epc, "EPCR");
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_EEAR), eear, "EEAR");
		expect_read(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_ESR),
			{16'h0, old_sr}, "ESR");
		d = take_bits(16);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR), d);
		rfe = 1'b1;
		@(negedge clk);
		rfe = 1'b0;
		if (sr !== old_sr)
			note_mismatch("sr_o after rfe", {16'h0, sr}, {16'h0, old_sr});
	endtask

	task automatic flag_and_carry();
		cpu_state_pkg::sr_fields_t expect_sr;
		logic [31:0]               d;
		d = take_bits(16);
		expect_sr = d[15:0] | 16'h8000;
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR), d);
		alu = {1'b1, ~expect_sr.F, 1'b0, 1'b0}; // Flag only
		@(negedge clk);
		alu = '0;
		expect_sr.F = ~expect_sr.F;
		if (sr !== expect_sr)
			note_mismatch("sr_o after flag update", {16'h0, sr}, {16'h0, expect_sr});
		alu = {1'b0, 1'b0, 1'b1, ~expect_sr.CY};
		@(negedge clk);
		alu = '0;
		expect_sr.CY = ~expect_sr.CY;
		if (sr !== expect_sr)
			note_mismatch("sr_o after carry update", {16'h0, sr}, {16'h0, expect_sr});
		// ALU and SR write in one cycle
		d = take_bits(16);
		expect_sr = d[15:0] | 16'h8000;
		cpu_req = make_req(cpu_state_pkg::MTSPR,
			make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR), d);
		alu = {1'b1, ~expect_sr.F, 1'b1, ~expect_sr.CY};
		@(negedge clk);
		cpu_req = '0;
		alu     = '0;
		expect_sr.F  = ~expect_sr.F;
		expect_sr.CY = ~expect_sr.CY;
		if (sr !== expect_sr)
			note_mismatch("sr_o after write with ALU", {16'h0, sr}, {16'h0, expect_sr});
	endtask

	task automatic interrupt_paths();
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_SYS, spr_map_pkg::SPR_SR), 32'h8007);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_PIC, spr_map_pkg::SPR_PICSR), 32'h0);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_PIC, spr_map_pkg::SPR_PICMR), 32'h8);
		irq[3] = 1'b1;
		@(negedge clk);
		irq = '0;
		wait_int(1'b0, 1'b1);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_PIC, spr_map_pkg::SPR_PICSR), 32'h0);
		wait_int(1'b0, 1'b0);
		// Masked line must stay silent
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_PIC, spr_map_pkg::SPR_PICMR), 32'h0);
		irq[3] = 1'b1;
		@(negedge clk);
		irq = '0;
		repeat (4) begin
			@(negedge clk);
			if (pic_int !== 1'b0)
				note_mismatch("pic_int_o while masked", {31'h0, pic_int}, 32'h0);
		end
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_TT, spr_map_pkg::SPR_TTCR), 32'h0);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_TT, spr_map_pkg::SPR_TTMR),
			{2'b01, 1'b1, 1'b0, 28'd12}); // Restart mode, IE, period 12
		wait_int(1'b1, 1'b1);
		write_spr(1'b0, make_addr(spr_map_pkg::GRP_TT, spr_map_pkg::SPR_TTMR),
			{2'b01, 1'b1, 1'b0, 28'd12});
		wait_int(1'b1, 1'b0);
	endtask

	initial begin
		lfsr_state = 32'hb71;
		mismatches = 0;
		timeouts   = 0;
		rst        = 1'b1;
		cpu_req    = '0;
		dbg_req    = '0;
		alu        = '0;
		exc        = '0;
		rfe        = 1'b0;
		irq        = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_reset_state();
		round_trip();
		debug_priority();
		exception_entry_return();
		flag_and_carry();
		interrupt_paths();
		$display("Finished with %0d mismatches and %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: sources.f
logic/spr_map_pkg.sv
logic/cpu_state_pkg.sv
logic/spr_access.sv
logic/sys_sprs.sv
logic/pic_sprs.sv
logic/tick_timer.sv
logic/spr_subsys.sv
dv/spr_subsys_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f --top-module spr_subsys_tb
	@out="$$(./obj_dir/Vspr_subsys_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
